// File: Makefile
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Simulation completed successfully
VFLAGS    ?= --binary --timing --assert
SOURCES   ?= $(wildcard design/*.sv test/*.sv)

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/cache_array_if.sv
`timescale 1ns/1ps

interface cache_array_if;

   // request address, shared by both arrays
   cache_pkg::cache_addr_u addr;

   // write strobes
   // line_sel_wr loads a whole line from the bus
   logic line_sel_wr;
   // store_wr writes the masked processor bytes
   logic store_wr;
   logic [cache_pkg::line_w-1:0] fill_line;

   // tag store replies
   logic hit;
   logic dirty;
   logic [cache_pkg::tag_w-1:0] victim_tag;

   // raw line at the index, used for writeback
   logic [cache_pkg::line_w-1:0] victim_line;

   modport ctrl (output addr, line_sel_wr, store_wr, fill_line,
                 input hit, dirty, victim_tag);

   modport tags (input addr, line_sel_wr, store_wr,
                 output hit, dirty, victim_tag);

   modport data (input addr, line_sel_wr, store_wr, fill_line,
                 output victim_line);

endinterface

// File: design/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
   input  logic clk,
   input  logic arst_n,
   input  logic enable,
   input  logic rw,
   input  logic [cache_pkg::addr_w-1:0] address,
   output logic ready,
   output logic bus_en,
   output logic bus_wr,
   output logic [cache_pkg::addr_w-1:0] bus_addr,
   input  logic [cache_pkg::line_w-1:0] bus_read,
   input  logic bus_r,
   cache_array_if.ctrl arr
);

   cache_pkg::state_t state;
   cache_pkg::state_t next_state;
   cache_pkg::cache_addr_u bus_a;

   // state register
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         state <= cache_pkg::st_idle;
      else
         state <= next_state;
   end

   // next state
   always_comb
   begin
      next_state = state;
      unique case (state)
         cache_pkg::st_idle:
         begin
            // request held until ready
            if (enable)
               next_state = cache_pkg::st_lookup;
         end
         cache_pkg::st_lookup:
         begin
            if (arr.hit)
               next_state = cache_pkg::st_hit;
            else if (arr.dirty)
               next_state = cache_pkg::st_evict;
            else
               next_state = cache_pkg::st_fill;
         end
         cache_pkg::st_evict:
         begin
            // writeback done, go fetch the new line
            if (bus_r)
               next_state = cache_pkg::st_fill;
         end
         cache_pkg::st_fill:
         begin
            // retry the lookup, it hits now
            if (bus_r)
               next_state = cache_pkg::st_lookup;
         end
         cache_pkg::st_hit:
            next_state = cache_pkg::st_idle;
         default:
            next_state = cache_pkg::st_idle;
      endcase
   end

   // array side
   assign arr.addr.raw = address;
   assign arr.fill_line = bus_read;
   // fill only in the bus_r cycle
   assign arr.line_sel_wr = (state == cache_pkg::st_fill) && bus_r;
   // stored at the end of the ready cycle
   assign arr.store_wr = (state == cache_pkg::st_hit) && rw;

   // processor side
   assign ready = (state == cache_pkg::st_hit);

   // bus strobes
   assign bus_en = (state == cache_pkg::st_evict) || (state == cache_pkg::st_fill);
   assign bus_wr = (state == cache_pkg::st_evict);

   // bus address, line aligned
   always_comb
   begin
      bus_a.raw = address;
      bus_a.fields.offset = '0;
      // victim tag on writeback
      if (state == cache_pkg::st_evict)
         bus_a.fields.tag = arr.victim_tag;
   end

   assign bus_addr = bus_a.raw;

endmodule

// File: design/cache_data_array.sv
`timescale 1ns/1ps

module cache_data_array (
   input  logic clk,
   input  logic [1:0] size,
   input  logic [cache_pkg::line_w-1:0] data_write,
   output logic [cache_pkg::line_w-1:0] data_read,
   cache_array_if.data arr
);

   // line storage
   logic [cache_pkg::line_w-1:0] lines [cache_pkg::num_lines];

   logic [cache_pkg::index_w-1:0] idx;
   logic [cache_pkg::offset_w-1:0] offset;
   logic [cache_pkg::offset_w+2:0] bit_shift;

   logic [cache_pkg::line_bytes-1:0] base_mask;
   logic [cache_pkg::line_bytes-1:0] store_mask;
   logic [cache_pkg::line_bytes-1:0] wr_mask;
   logic [cache_pkg::line_w-1:0] store_data;
   logic [cache_pkg::line_w-1:0] wr_data;
   logic [cache_pkg::line_w-1:0] raw_line;

   assign idx = arr.addr.fields.index;
   assign offset = arr.addr.fields.offset;
   // offset in bytes to bits
   assign bit_shift = {offset, 3'b000};

   // 2^size low bytes
   always_comb
   begin
      unique case (size)
         2'd0: base_mask = 16'h0001;
         2'd1: base_mask = 16'h0003;
         2'd2: base_mask = 16'h000f;
         default: base_mask = 16'h00ff;
      endcase
   end

   // lanes past byte 15 fall off the top
   assign store_mask = base_mask << offset;
   assign store_data = data_write << bit_shift;

   // fill takes every byte from the bus
   assign wr_mask = arr.line_sel_wr ? '1 : (arr.store_wr ? store_mask : '0);
   assign wr_data = arr.line_sel_wr ? arr.fill_line : store_data;

   // byte write enables
   always_ff @(posedge clk)
   begin
      for (int b = 0; b < cache_pkg::line_bytes; b++)
      begin
         if (wr_mask[b])
            lines[idx][b*8 +: 8] <= wr_data[b*8 +: 8];
      end
   end

   // read port
   assign raw_line = lines[idx];
   assign arr.victim_line = raw_line;
   // addressed byte lands in 7:0, zero filled
   assign data_read = raw_line >> bit_shift;

endmodule

// File: design/cache_pkg.sv
package cache_pkg;

   // address split 7 / 5 / 4
   localparam int tag_w = 7;
   localparam int index_w = 5;
   localparam int offset_w = 4;
   localparam int addr_w = tag_w + index_w + offset_w;

   // line geometry
   localparam int line_bytes = 16;
   localparam int line_w = line_bytes * 8;
   localparam int num_lines = 32;

   // one-hot controller states
   typedef enum logic [4:0] {
      st_idle   = 5'b00001,
      st_lookup = 5'b00010,
      st_evict  = 5'b00100,
      st_fill   = 5'b01000,
      st_hit    = 5'b10000
   } state_t;

   // same address word, seen whole or split
   typedef union packed {
      logic [addr_w-1:0] raw;
      struct packed {
         logic [tag_w-1:0] tag;
         logic [index_w-1:0] index;
         logic [offset_w-1:0] offset;
      } fields;
   } cache_addr_u;

endpackage

// File: design/cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store (
   input logic clk,
   input logic arst_n,
   cache_array_if.tags arr
);

   // tag and dirty per line
   logic [cache_pkg::tag_w-1:0] tag_mem [cache_pkg::num_lines];
   logic [cache_pkg::num_lines-1:0] dirty_bits;
   // valid bits
   logic [cache_pkg::num_lines-1:0] valid_bits;

   logic [cache_pkg::index_w-1:0] idx;
   logic [cache_pkg::tag_w-1:0] req_tag;
   logic line_valid;

   assign idx = arr.addr.fields.index;
   assign req_tag = arr.addr.fields.tag;
   assign line_valid = valid_bits[idx];

   // only fills make a line valid
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         valid_bits <= '0;
      else if (arr.line_sel_wr)
         valid_bits[idx] <= 1'b1;
   end

   // fill loads tag and cleans the line
   // store marks it dirty
   always_ff @(posedge clk)
   begin
      if (arr.line_sel_wr)
      begin
         tag_mem[idx] <= req_tag;
         dirty_bits[idx] <= 1'b0;
      end
      else if (arr.store_wr)
      begin
         dirty_bits[idx] <= 1'b1;
      end
   end

   // hit compare
   assign arr.hit = line_valid && (tag_mem[idx] == req_tag);
   // invalid line is never dirty
   assign arr.dirty = line_valid && dirty_bits[idx];
   // for the writeback address
   assign arr.victim_tag = tag_mem[idx];

endmodule

// File: design/cache_top.sv
`timescale 1ns/1ps

module cache_top (
   input  logic clk,
   input  logic arst_n,
   // processor port
   input  logic enable,
   input  logic rw,
   input  logic [cache_pkg::addr_w-1:0] address,
   input  logic [1:0] size,
   input  logic [cache_pkg::line_w-1:0] data_write,
   output logic [cache_pkg::line_w-1:0] data_read,
   output logic ready,
   // memory bus
   output logic bus_en,
   output logic bus_wr,
   output logic [cache_pkg::addr_w-1:0] bus_addr,
   output logic [cache_pkg::line_w-1:0] bus_write,
   input  logic bus_r,
   input  logic [cache_pkg::line_w-1:0] bus_read
);

   // controller to arrays
   cache_array_if arr ();

   cache_ctrl cache_ctrl_inst (
      .clk      (clk),
      .arst_n   (arst_n),
      .enable   (enable),
      .rw       (rw),
      .address  (address),
      .ready    (ready),
      .bus_en   (bus_en),
      .bus_wr   (bus_wr),
      .bus_addr (bus_addr),
      .bus_read (bus_read),
      .bus_r    (bus_r),
      .arr      (arr.ctrl)
   );

   cache_tag_store cache_tag_store_inst (
      .clk    (clk),
      .arst_n (arst_n),
      .arr    (arr.tags)
   );

   cache_data_array cache_data_array_inst (
      .clk        (clk),
      .size       (size),
      .data_write (data_write),
      .data_read  (data_read),
      .arr        (arr.data)
   );

   // writeback data is the indexed line
   assign bus_write = arr.victim_line;

endmodule

// File: test/cache_checker.sv
`timescale 1ns/1ps

module cache_checker (
   input logic clk,
   input logic arst_n,
   input logic ready,
   input logic bus_en,
   input logic bus_wr,
   input logic [cache_pkg::addr_w-1:0] bus_addr,
   input logic bus_r,
   input cache_pkg::state_t state
);

   // ready is a single-cycle pulse
   assert property (@(posedge clk) disable iff (!arst_n) ready |=> !ready)
      else $error("ready held longer than one cycle");

   // bus request held steady until completion
   assert property (@(posedge clk) disable iff (!arst_n)
      (bus_en && !bus_r) |=> (bus_en && $stable(bus_wr) && $stable(bus_addr)))
      else $error("bus request changed before bus_r");

   assert property (@(posedge clk) disable iff (!arst_n) bus_wr |-> bus_en)
      else $error("bus_wr without bus_en");

   // quiet outputs and idle state right after reset release
   assert property (@(posedge clk) $rose(arst_n)
      |-> (!ready && !bus_en && !bus_wr && state == cache_pkg::st_idle))
      else $error("outputs active or state not idle after reset");

endmodule

bind cache_top cache_checker cache_checker_inst (
   .clk      (clk),
   .arst_n   (arst_n),
   .ready    (ready),
   .bus_en   (bus_en),
   .bus_wr   (bus_wr),
   .bus_addr (bus_addr),
   .bus_r    (bus_r),
   .state    (cache_ctrl_inst.state)
);

// File: test/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

   localparam int num_tests = 6;

   logic clk, arst_n, enable, rw, ready, bus_en, bus_wr, bus_r;
   logic [1:0] size;
   logic [15:0] address, bus_addr;
   logic [127:0] data_write, data_read, bus_write, bus_read;

   // bus memory and the processor's view of data
   logic [127:0] bus_mem [int];
   logic [7:0] shadow [int];
   integer seed = 86;
   int errors = 0;
   int tests_done = 0;
   int fills = 0, wbs = 0, bus_cnt = -1, cyc, t, i, k;
   logic [15:0] last_fill_addr, last_wb_addr, a;
   logic [127:0] last_wb_data, wd;

   cache_top cache_top_inst (.*);

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial
   begin
      #(2000 * num_tests * 4);
      $display("Watchdog timeout, the tests did not finish in time");
      $display("Simulation failed");
      $finish;
   end

   // low address byte xor high address byte xor 5a
   function automatic logic [127:0] pattern_line(input int ln);
      logic [127:0] l;
      logic [15:0] ba;
      for (int b = 0; b < 16; b++)
      begin
         ba = 16'(ln * 16 + b);
         l[b*8 +: 8] = ba[7:0] ^ ba[15:8] ^ 8'h5a;
      end
      return l;
   endfunction

   function automatic logic [127:0] mem_line(input int ln);
      if (bus_mem.exists(ln))
         return bus_mem[ln];
      return pattern_line(ln);
   endfunction

   // pattern with the processor's stores on top
   function automatic logic [127:0] shadow_line(input int ln);
      logic [127:0] l;
      l = pattern_line(ln);
      for (int b = 0; b < 16; b++)
         if (shadow.exists(ln * 16 + b))
            l[b*8 +: 8] = shadow[ln * 16 + b];
      return l;
   endfunction

   // bus model answers after 1 to 4 cycles
   initial
   begin
      bus_r = 1'b0;
      bus_read = '0;
      forever
      begin
         @(negedge clk);
         if (bus_r)
         begin
            bus_r = 1'b0;
            bus_cnt = -1;
         end
         if (bus_en)
         begin
            if (bus_cnt < 0)
               bus_cnt = $unsigned($random(seed)) % 4;
            if (bus_cnt == 0)
            begin
               bus_r = 1'b1;
               if (bus_wr)
               begin
                  bus_mem[int'(bus_addr[15:4])] = bus_write;
                  wbs++;
                  last_wb_addr = bus_addr;
                  last_wb_data = bus_write;
               end
               else
               begin
                  bus_read = mem_line(int'(bus_addr[15:4]));
                  fills++;
                  last_fill_addr = bus_addr;
               end
            end
            else
               bus_cnt--;
         end
      end
   end

   // drive one request and wait for ready
   task automatic access(input logic wr, input logic [15:0] ad, input logic [1:0] sz,
                         input logic [127:0] wdat, output int cycles);
      int off;
      int ln;
      logic [127:0] exp, line;
      enable = 1'b1;
      rw = wr;
      address = ad;
      size = sz;
      data_write = wdat;
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
      end while (!ready);
      off = int'(ad[3:0]);
      ln = int'(ad[15:4]);
      line = shadow_line(ln);
      if (!wr)
      begin
         // expected line shifted right by the offset
         exp = line >> (off * 8);
         assert (data_read === exp)
         else
         begin
            $display("Fail at %0t: read %h got %h expected %h", $time, ad, data_read, exp);
            errors++;
         end
      end
      else
         for (int b = 0; b < (1 << sz); b++)
            if (off + b < 16)
               shadow[ln * 16 + off + b] = wdat[b*8 +: 8];
      enable = 1'b0;
      // back in idle before the next request
      @(negedge clk);
   endtask

   task automatic check(input logic ok, input string msg);
      assert (ok)
      else
      begin
         $display("Fail at %0t: %s", $time, msg);
         errors++;
      end
   endtask

   task automatic test_done(input string name);
      tests_done++;
      $display("test %0d %s finished, errors so far %0d", tests_done, name, errors);
   endtask

   initial
   begin
      arst_n = 1'b0;
      enable = 1'b0;
      rw = 1'b0;
      address = '0;
      size = '0;
      data_write = '0;
      repeat (10) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      access(1'b0, 16'h1234, 2'd0, '0, cyc);
      check(fills == 1 && wbs == 0 && last_fill_addr == 16'h1230, "cold miss bus traffic");
      test_done("cold read miss");

      access(1'b0, 16'h1238, 2'd0, '0, cyc);
      check(cyc == 2 && fills == 1 && wbs == 0, "read hit timing or bus activity");
      test_done("read hit timing");

      // each size at a spread of offsets including lanes past byte 15
      for (k = 0; k < 7; k++)
      begin
         wd = {$random(seed), $random(seed), $random(seed), $random(seed)};
         a = 16'h1230 + 16'(k * 5 % 16);
         access(1'b1, a, 2'(k % 4), wd, cyc);
         access(1'b0, a, 2'd0, '0, cyc);
         access(1'b0, 16'h1230, 2'd0, '0, cyc);
      end
      test_done("sized stores");

      access(1'b0, 16'h1030, 2'd0, '0, cyc);
      check(wbs == 1 && last_wb_addr == 16'h1230 && last_wb_data === shadow_line(16'h123),
            "dirty eviction writeback");
      check(fills == 2 && last_fill_addr == 16'h1030, "fill after eviction");
      test_done("dirty eviction");

      access(1'b0, 16'h1230, 2'd0, '0, cyc);
      check(wbs == 1 && fills == 3, "clean replacement traffic");
      test_done("clean replacement");

      for (k = 0; k < 200; k++)
      begin
         t = ($unsigned($random(seed)) % 4) * 512 + ($unsigned($random(seed)) % 4) * 16;
         a = 16'(t + $unsigned($random(seed)) % 16);
         wd = {$random(seed), $random(seed), $random(seed), $random(seed)};
         access(1'($random(seed)), a, 2'($random(seed)), wd, cyc);
      end
      // unused tag forces every dirty line out
      for (i = 0; i < 4; i++)
         access(1'b0, 16'(8 * 512 + i * 16), 2'd0, '0, cyc);
      for (t = 0; t < 4; t++)
         for (i = 0; i < 4; i++)
            check(mem_line(t * 32 + i) === shadow_line(t * 32 + i), "bus memory mismatch");
      test_done("random mix");

      $display("tests run %0d, errors %0d", tests_done, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// File: vlog.f
design/cache_pkg.sv
design/cache_array_if.sv
design/cache_tag_store.sv
design/cache_data_array.sv
design/cache_ctrl.sv
design/cache_top.sv
test/cache_checker.sv
test/cache_tb.sv
